// File: Makefile
# Verilator build and run of the memory subsystem testbench
TOP := tb_mem_subsys

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: design/bist_ctrl.sv
// march FSM, host and test arbitration of the memory, sticky fail and done pulse
`timescale 1ns/1ns

module bist_ctrl
    import mem_cfg_pkg::*;
    import bist_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              bist_start,        // start pulse
    input  logic              ce,                // host chip enable
    input  logic              we,                // host write enable
    input  logic [mem_dw-1:0] wmask,             // host write mask
    input  logic [mem_dw-1:0] din,               // host write data
    input  logic [mem_aw-1:0] addr,              // host address
    input  logic [mem_aw-1:0] test_addr,         // from test datapath
    input  logic [mem_dw-1:0] test_wdata,        // from test datapath
    input  logic              addr_last,         // end of current element
    input  logic              mismatch,          // compare result of last read
    output logic              mem_ce,
    output logic              mem_we,
    output logic [mem_aw-1:0] mem_addr,
    output logic [mem_dw-1:0] mem_wmask,
    output logic [mem_dw-1:0] mem_din,
    output logic              addr_clear,
    output logic              addr_step,
    output logic              addr_down,
    output logic              pattern_hi,
    output logic              cmp_arm,
    output logic              bist_busy,
    output logic              bist_done,
    output logic              bist_fail
);

    bist_state_e state_q, state_d;               // FSM state
    march_elem_e elem_q, elem_d;                 // element being run
    logic        test_strobe;                    // test owns a strobe this cycle
    logic        fail_q;                         // sticky mismatch flag

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= idle;
            elem_q  <= w0_up;
        end else begin
            state_q <= state_d;
            elem_q  <= elem_d;
        end
    end

    // march sequencing with counter control on each transition
    always_comb begin
        state_d    = state_q;
        elem_d     = elem_q;
        addr_clear = 1'b0;
        addr_step  = 1'b0;
        addr_down  = 1'b0;
        case (state_q)
            idle, finish: begin
                state_d = idle;
                if (bist_start) begin            // accepted whenever not busy
                    state_d    = run_write;
                    elem_d     = w0_up;
                    addr_clear = 1'b1;           // ascending from word 0
                end
            end
            run_write: begin
                if (addr_last) begin
                    state_d    = run_read;       // every later element opens with a read
                    addr_clear = 1'b1;
                    case (elem_q)
                        w0_up:   elem_d = r0w1_up;
                        r0w1_up: begin
                            elem_d    = r1w0_down;
                            addr_down = 1'b1;    // only descending element
                        end
                        default: elem_d = r0_up;
                    endcase
                end else begin
                    addr_step = 1'b1;
                    state_d   = (elem_q == w0_up) ? run_write : run_read;
                end
            end
            run_read: begin
                if (elem_q != r0_up) begin
                    state_d = run_write;         // write back to the same word
                end else if (addr_last) begin
                    state_d = drain;
                end else begin
                    addr_step = 1'b1;
                end
            end
            drain:   state_d = finish;           // last compare happens here
            default: state_d = idle;
        endcase
    end

    assign bist_busy   = (state_q == run_read) || (state_q == run_write) || (state_q == drain);
    assign bist_done   = (state_q == finish);
    assign test_strobe = (state_q == run_read) || (state_q == run_write);

    // pattern that a read expects or a write stores in this element
    assign pattern_hi = ((state_q == run_read) && (elem_q == r1w0_down))
                     || ((state_q == run_write) && (elem_q == r0w1_up));
    assign cmp_arm    = (state_q == run_read);

    // host is locked out of the memory for the whole busy window
    assign mem_ce    = test_strobe || (!bist_busy && ce);
    assign mem_we    = test_strobe ? (state_q == run_write) : we;
    assign mem_addr  = bist_busy ? test_addr : addr;
    assign mem_wmask = bist_busy ? '1 : wmask;   // test writes whole words
    assign mem_din   = bist_busy ? test_wdata : din;

    // sticky fail flag cleared by an accepted start
    always_ff @(posedge clk) begin
        if (reset) begin
            fail_q <= 1'b0;
        end else if (!bist_busy && bist_start) begin
            fail_q <= 1'b0;
        end else if (mismatch) begin
            fail_q <= 1'b1;
        end
    end

    assign bist_fail = fail_q;

    a_done_pulse : assert property (
        @(posedge clk) disable iff (reset) bist_done |=> !bist_done
    ) else $error("bist_ctrl: bist_done held for two cycles");

endmodule

// File: design/bist_datapath.sv
// test address counter, pattern word, expected value pipeline and read compare
`timescale 1ns/1ns

module bist_datapath
    import mem_cfg_pkg::*;
    import bist_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              addr_clear,        // load start address of an element
    input  logic              addr_step,         // advance one word
    input  logic              addr_down,         // direction taken on addr_clear
    input  logic              pattern_hi,        // select all ones pattern
    input  logic              cmp_arm,           // a test read is strobed now
    input  logic [mem_dw-1:0] rdata,             // memory read data
    output logic [mem_aw-1:0] test_addr,         // test address to memory
    output logic [mem_dw-1:0] test_wdata,        // pattern to memory and compare
    output logic              addr_last,         // counter at end of element
    output logic              mismatch           // read data differs from expected
);

    logic [mem_aw-1:0] addr_q;                   // current test address
    logic              dir_q;                    // 1 when counting down
    logic              armed_q;                  // a read was strobed last cycle
    logic [mem_dw-1:0] exp_q;                    // expected word of that read

    // address counter; the direction is latched with the start address
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
            dir_q  <= 1'b0;
        end else if (addr_clear) begin
            addr_q <= addr_down ? '1 : '0;       // top or bottom of the array
            dir_q  <= addr_down;
        end else if (addr_step) begin
            addr_q <= dir_q ? addr_q - 1'b1 : addr_q + 1'b1;
        end
    end

    assign test_addr  = addr_q;
    assign addr_last  = dir_q ? (addr_q == '0) : (addr_q == '1);
    assign test_wdata = pattern_hi ? pat_one : pat_zero;

    // expected word tracks each read, so reads on consecutive cycles work
    always_ff @(posedge clk) begin
        if (reset) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= cmp_arm;
        end
    end

    always_ff @(posedge clk) begin
        if (cmp_arm) begin
            exp_q <= test_wdata;                 // pattern_hi holds the read value
        end
    end

    // compare in the cycle the macro data is valid
    assign mismatch = armed_q && (rdata != exp_q);

endmodule

// File: design/bist_pkg.sv
// march element and FSM state encodings plus data pattern constants
package bist_pkg;

    // four elements of the march, run in this order
    typedef enum logic [1:0] {
        w0_up     = 2'd0,                        // write 0, ascending
        r0w1_up   = 2'd1,                        // read 0 then write 1, ascending
        r1w0_down = 2'd2,                        // read 1 then write 0, descending
        r0_up     = 2'd3                         // final read 0, ascending
    } march_elem_e;

    // controller states
    typedef enum logic [2:0] {
        idle      = 3'd0,                        // host owns the memory
        run_read  = 3'd1,                        // test read strobe this cycle
        run_write = 3'd2,                        // test write strobe this cycle
        drain     = 3'd3,                        // last read still being compared
        finish    = 3'd4                         // done pulse, busy already low
    } bist_state_e;

    // background patterns, full data width
    localparam logic [mem_cfg_pkg::mem_dw-1:0] pat_zero = '0;   // all zeros
    localparam logic [mem_cfg_pkg::mem_dw-1:0] pat_one  = '1;   // all ones

endpackage

// File: design/mem_cfg_pkg.sv
// memory geometry localparams and the split address union
package mem_cfg_pkg;

    // full array as seen by the host
    localparam int mem_dw = 64;                  // data width
    localparam int mem_aw = 8;                   // 256 words

    // one behavioral hard macro
    localparam int macro_dw = 32;                // macro word width
    localparam int macro_aw = 6;                 // 64 rows per macro

    // tiling of macros into the array
    localparam int bank_cnt  = 4;                // banks stacked in depth
    localparam int slice_cnt = 2;                // macros side by side per bank

    // The same 8-bit address word is read two ways. Host and test counter
    // see a flat index, the tiler splits it into bank and macro row.
    typedef union packed {
        logic [mem_aw-1:0] flat;                 // linear word address
        struct packed {
            logic [mem_aw-macro_aw-1:0] bank;    // upper bits pick the bank
            logic [macro_aw-1:0]        row;     // row inside each macro
        } split;
    } mem_addr_u;

endpackage

// File: design/mem_subsys.sv
// top level of the RAM subsystem with march self test
`timescale 1ns/1ns

module mem_subsys
    import mem_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ce,                // host chip enable
    input  logic              we,                // host write enable
    input  logic              bist_start,        // self test start pulse
    input  logic [mem_dw-1:0] wmask,             // host per bit mask
    input  logic [mem_dw-1:0] din,               // host write data
    input  logic [mem_aw-1:0] addr,              // host address
    output logic [mem_dw-1:0] dout,              // read data
    output logic              bist_busy,
    output logic              bist_done,
    output logic              bist_fail
);

    // arbitrated memory strobes
    logic              mem_ce;
    logic              mem_we;
    logic [mem_aw-1:0] mem_addr;
    logic [mem_dw-1:0] mem_wmask;
    logic [mem_dw-1:0] mem_din;

    // control to test datapath
    logic              addr_clear;
    logic              addr_step;
    logic              addr_down;
    logic              pattern_hi;
    logic              cmp_arm;

    // test datapath back to control
    logic [mem_aw-1:0] test_addr;
    logic [mem_dw-1:0] test_wdata;
    logic              addr_last;
    logic              mismatch;

    bist_ctrl i_bist_ctrl (
        .clk        (clk),
        .reset      (reset),
        .bist_start (bist_start),
        .ce         (ce),
        .we         (we),
        .wmask      (wmask),
        .din        (din),
        .addr       (addr),
        .test_addr  (test_addr),
        .test_wdata (test_wdata),
        .addr_last  (addr_last),
        .mismatch   (mismatch),
        .mem_ce     (mem_ce),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wmask  (mem_wmask),
        .mem_din    (mem_din),
        .addr_clear (addr_clear),
        .addr_step  (addr_step),
        .addr_down  (addr_down),
        .pattern_hi (pattern_hi),
        .cmp_arm    (cmp_arm),
        .bist_busy  (bist_busy),
        .bist_done  (bist_done),
        .bist_fail  (bist_fail)
    );

    bist_datapath i_bist_datapath (
        .clk        (clk),
        .reset      (reset),
        .addr_clear (addr_clear),
        .addr_step  (addr_step),
        .addr_down  (addr_down),
        .pattern_hi (pattern_hi),
        .cmp_arm    (cmp_arm),
        .rdata      (dout),                      // compares the shared read port
        .test_addr  (test_addr),
        .test_wdata (test_wdata),
        .addr_last  (addr_last),
        .mismatch   (mismatch)
    );

    spram_tiler i_spram_tiler (
        .clk   (clk),
        .reset (reset),
        .ce    (mem_ce),
        .we    (mem_we),
        .addr  (mem_addr),
        .wmask (mem_wmask),
        .din   (mem_din),
        .dout  (dout)
    );

endmodule

// File: design/spram_tiler.sv
// 256x64 array tiled from eight 64x32 macros with bank decode and read mux
`timescale 1ns/1ns

module spram_tiler
    import mem_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ce,                // chip enable
    input  logic              we,                // write enable
    input  logic [mem_aw-1:0] addr,              // flat word address
    input  logic [mem_dw-1:0] wmask,             // per bit write mask
    input  logic [mem_dw-1:0] din,               // write data
    output logic [mem_dw-1:0] dout               // read data, one cycle after strobe
);

    mem_addr_u                      addr_u;      // address seen through the split view
    logic [bank_cnt-1:0]            bank_ce;     // one chip enable per bank
    logic [mem_aw-macro_aw-1:0]     rd_bank_q;   // bank of the last read strobe
    logic [mem_dw-1:0]              bank_rd [bank_cnt];  // read words of each bank

    assign addr_u.flat = addr;

    // bank decode from the upper address bits
    always_comb begin
        for (int b = 0; b < bank_cnt; b++) begin
            bank_ce[b] = ce && (addr_u.split.bank == b);
        end
    end

    // remember which bank answers the pending read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_bank_q <= '0;
        end else if (ce && !we) begin
            rd_bank_q <= addr_u.split.bank;      // writes leave the mux alone
        end
    end

    // each bank is slice_cnt macros wide, all share the row address
    for (genvar b = 0; b < bank_cnt; b++) begin : g_bank
        for (genvar s = 0; s < slice_cnt; s++) begin : g_slice
            sram_macro i_sram_macro (
                .clk       (clk),
                .ce_in     (bank_ce[b]),
                .we_in     (we),
                .addr_in   (addr_u.split.row),
                .wd_in     (din[s*macro_dw +: macro_dw]),
                .w_mask_in (wmask[s*macro_dw +: macro_dw]),
                .rd_out    (bank_rd[b][s*macro_dw +: macro_dw])
            );
        end
    end

    // macros of idle banks hold their last word, so pick by registered bank
    assign dout = bank_rd[rd_bank_q];

    // decode must never fire two banks at once
    a_one_bank : assert property (
        @(posedge clk) disable iff (reset) $onehot0(bank_ce)
    ) else $error("spram_tiler: more than one bank enabled");

endmodule

// File: design/sram_macro.sv
// behavioral 64x32 single port macro with bit-masked write and registered read
`timescale 1ns/1ns

module sram_macro
    import mem_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                ce_in,          // chip enable
    input  logic                we_in,          // write enable, qualified by ce
    input  logic [macro_aw-1:0] addr_in,        // row address
    input  logic [macro_dw-1:0] wd_in,          // write data
    input  logic [macro_dw-1:0] w_mask_in,      // per bit write mask
    output logic [macro_dw-1:0] rd_out          // registered read data
);

    logic [macro_dw-1:0] mem [2**macro_aw];      // storage array, no reset
    logic [macro_dw-1:0] rd_q;                   // output latch of the macro

    // masked write keeps the untouched bits
    always_ff @(posedge clk) begin
        if (ce_in && we_in) begin
            mem[addr_in] <= (mem[addr_in] & ~w_mask_in) | (wd_in & w_mask_in);
        end
    end

    // read port updates only on a read strobe
    always_ff @(posedge clk) begin
        if (ce_in && !we_in) begin
            rd_q <= mem[addr_in];                // old data, write and read exclusive
        end
    end

    assign rd_out = rd_q;                        // held between reads

    // an unknown row with ce high would corrupt or read an arbitrary word
    a_addr_known : assert property (
        @(posedge clk) ce_in |-> !$isunknown(addr_in)
    ) else $error("sram_macro: unknown address with ce_in high");

endmodule

// File: sim.f
design/mem_cfg_pkg.sv
design/bist_pkg.sv
design/sram_macro.sv
design/spram_tiler.sv
design/bist_datapath.sv
design/bist_ctrl.sv
design/mem_subsys.sv
testbench/tb_mem_subsys.sv

// File: testbench/tb_mem_subsys.sv
// mem_subsys testbench with clock, reset, host and self test stimulus, shadow model and compare
`timescale 1ns/1ns

module tb_mem_subsys
    import mem_cfg_pkg::*;
();

    localparam int march_len  = 1537;            // busy cycles of one march run
    localparam int n_full     = 2**mem_aw;       // one pass over the array
    localparam int n_partial  = 300;             // masked write plus read pairs
    localparam int n_b2b      = 64;              // back to back reads
    localparam int n_prewrite = 64;              // host writes before second march
    localparam int test_len   = 2*march_len + 4*n_full + 2*n_partial + n_b2b + n_prewrite + 100;
    localparam int timeout_cycles = 2*test_len;

    logic              clk = 1'b0;
    logic              reset;
    logic              ce;
    logic              we;
    logic              bist_start;
    logic [mem_dw-1:0] wmask;
    logic [mem_dw-1:0] din;
    logic [mem_aw-1:0] addr;
    logic [mem_dw-1:0] dout;
    logic              bist_busy;
    logic              bist_done;
    logic              bist_fail;

    logic [mem_dw-1:0] shadow [2**mem_aw];       // expected memory contents
    logic [mem_dw-1:0] exp_q [$];                // expected word per pending read
    logic [mem_aw-1:0] addr_q [$];               // address per pending read
    int                tag_q [$];                // cycle in which the read was driven
    int                cyc = 0;                  // posedge count
    int                busy_cycles;
    logic [31:0]       rnd;
    logic [mem_dw-1:0] chk_exp;
    logic [mem_aw-1:0] chk_addr;

    mem_subsys i_mem_subsys (
        .clk        (clk),
        .reset      (reset),
        .ce         (ce),
        .we         (we),
        .bist_start (bist_start),
        .wmask      (wmask),
        .din        (din),
        .addr       (addr),
        .dout       (dout),
        .bist_busy  (bist_busy),
        .bist_done  (bist_done),
        .bist_fail  (bist_fail)
    );

    always #2 clk = ~clk;                        // 4 ns period

    // applies a masked write to the shadow and returns the stored word
    function automatic logic [mem_dw-1:0] shadow_access(input logic wr,
            input logic [mem_aw-1:0] a, input logic [mem_dw-1:0] m, input logic [mem_dw-1:0] d);
        if (wr) begin
            shadow[a] = (shadow[a] & ~m) | (d & m);  // only masked bits change
        end
        return shadow[a];
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        assert (got === expected) else
            abort_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
    endtask

    task automatic write_word(input logic [mem_aw-1:0] a, input logic [mem_dw-1:0] m,
            input logic [mem_dw-1:0] d);
        @(negedge clk);
        ce    = 1'b1;
        we    = 1'b1;
        addr  = a;
        wmask = m;
        din   = d;
        void'(shadow_access(1'b1, a, m, d));
    endtask

    task automatic read_word(input logic [mem_aw-1:0] a);
        @(negedge clk);
        ce    = 1'b1;
        we    = 1'b0;
        addr  = a;
        wmask = '0;
        din   = '0;
        exp_q.push_back(shadow_access(1'b0, a, '0, '0));
        addr_q.push_back(a);
        tag_q.push_back(cyc);                    // checked once cyc has moved on
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            ce = 1'b0;
            we = 1'b0;
        end
    endtask

    task automatic readback_all();
        for (int i = 0; i < n_full; i++) begin
            read_word(i[mem_aw-1:0]);
        end
        idle_cycles(2);                          // last compare
    endtask

    // one march run with ignored host traffic, then the shadow is zeroed
    task automatic run_march();
        idle_cycles(2);
        @(negedge clk);
        bist_start = 1'b1;
        @(negedge clk);
        bist_start = 1'b0;
        check_flag("bist_busy", bist_busy, 1'b1);
        busy_cycles = 0;
        while (bist_busy === 1'b1) begin
            check_flag("bist_done", bist_done, 1'b0);    // no done inside the run
            busy_cycles++;
            rnd   = $urandom;                    // host strobes the DUT must drop
            ce    = 1'b1;
            we    = rnd[0];
            addr  = rnd[15:8];
            wmask = {$urandom, $urandom};
            din   = {$urandom, $urandom};
            @(negedge clk);
        end
        ce = 1'b0;
        we = 1'b0;
        check_flag("bist_done", bist_done, 1'b1);    // done with busy already low
        check_flag("bist_fail", bist_fail, 1'b0);
        assert (busy_cycles == march_len) else
            abort_run($sformatf("self test was busy for %0d cycles instead of %0d",
                busy_cycles, march_len));
        @(negedge clk);
        check_flag("bist_done", bist_done, 1'b0);    // single cycle pulse
        for (int i = 0; i < n_full; i++) begin
            shadow[i] = '0;
        end
    endtask

    // compare one cycle after each read strobe
    always @(negedge clk) begin
        if (tag_q.size() > 0 && tag_q[0] < cyc) begin
            chk_exp  = exp_q.pop_front();
            chk_addr = addr_q.pop_front();
            void'(tag_q.pop_front());
            assert (dout === chk_exp) else
                abort_run($sformatf("[FAIL] dout at addr %h: got %h, expected %h",
                    chk_addr, dout, chk_exp));
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        assert (cyc < timeout_cycles) else
            abort_run($sformatf("timeout: test did not end within %0d cycles", timeout_cycles));
    end

    initial begin
        rnd        = $urandom(31028);
        reset      = 1'b1;
        ce         = 1'b0;
        we         = 1'b0;
        bist_start = 1'b0;
        wmask      = '0;
        din        = '0;
        addr       = '0;
        for (int i = 0; i < n_full; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_flag("bist_busy", bist_busy, 1'b0);
        check_flag("bist_done", bist_done, 1'b0);
        check_flag("bist_fail", bist_fail, 1'b0);

        for (int i = 0; i < n_full; i++) begin   // full mask fill of all banks
            write_word(i[mem_aw-1:0], '1, {$urandom, $urandom});
        end
        readback_all();

        repeat (n_partial) begin                 // partial mask write with a read right after
            rnd = $urandom;
            write_word(rnd[mem_aw-1:0], {$urandom, $urandom}, {$urandom, $urandom});
            read_word(rnd[mem_aw-1:0]);
        end
        idle_cycles(2);

        for (int i = 0; i < n_b2b; i++) begin    // bank changes on every read
            rnd = $urandom;
            read_word({i[1:0], rnd[macro_aw-1:0]});
        end
        idle_cycles(2);

        run_march();
        readback_all();

        repeat (n_prewrite) begin
            rnd = $urandom;
            write_word(rnd[mem_aw-1:0], {$urandom, $urandom}, {$urandom, $urandom});
        end
        run_march();
        readback_all();

        assert (tag_q.size() == 0) else abort_run("reads left without a compare");
        $display(">>> PASS");
        $finish;
    end

endmodule
